/* verilog/cnn_pkg.sv */
// Shared sizes, shift amount, datapath vector types and control state enum
`default_nettype none

package cnn_pkg;

    // Line geometry
    localparam int NUM_TAPS = 16;               // Weights and samples per line
    localparam int NUM_SUMS = NUM_TAPS / 2;     // Adjacent pair sums
    localparam int NUM_OUT  = NUM_SUMS / 2;     // Pooled outputs

    // Datapath widths
    localparam int DATA_W = 8;
    localparam int ADDR_W = $clog2(NUM_TAPS);
    localparam int PROD_W = 2 * DATA_W;
    localparam int SUM_W  = PROD_W + 1;         // One guard bit for the pair add

    // Requantization after pooling
    localparam int RESULT_SHIFT = 6;

    // Registered stages between a full line and valid sums
    localparam int PIPE_DEPTH = 2;
    localparam int WAIT_W     = $clog2(PIPE_DEPTH);
    localparam int OUT_IDX_W  = $clog2(NUM_OUT);

    // Element types carry their own sign so that a select stays signed
    typedef logic signed [DATA_W-1:0] operand_t;
    typedef logic signed [PROD_W-1:0] product_t;
    typedef logic        [SUM_W-1:0]  sum_t;    // ReLU output, never negative

    typedef operand_t [NUM_TAPS-1:0] operand_vec_t;
    typedef product_t [NUM_TAPS-1:0] product_vec_t;
    typedef sum_t     [NUM_SUMS-1:0] sum_vec_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_WEIGHTS,
        LOAD_LINE,
        COMPUTE,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/operand_buffer.sv */
// Sixteen-entry byte register file with parallel read-out
`default_nettype none

module operand_buffer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       we,
    input  logic [cnn_pkg::ADDR_W-1:0] addr,
    input  logic [cnn_pkg::DATA_W-1:0] data,
    output cnn_pkg::operand_vec_t      contents
);

    // Entry i sits at index i of the read-out vector
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            contents <= '0;                 // Buffer reads as zero until loaded
        end else if (we) begin
            contents[addr] <= data;
        end
    end

endmodule

`default_nettype wire

/* verilog/mac_array.sv */
// Sixteen signed multipliers with registered products
`default_nettype none

module mac_array (
    input  logic                  clk,
    input  logic                  reset,
    input  cnn_pkg::operand_vec_t weights,
    input  cnn_pkg::operand_vec_t samples,
    output cnn_pkg::product_vec_t products
);

    cnn_pkg::product_vec_t prod_next;

    // One multiplier per tap, operands sign extended to full product width
    for (genvar i = 0; i < cnn_pkg::NUM_TAPS; i++) begin : g_mult
        assign prod_next[i] = cnn_pkg::PROD_W'(weights[i]) * cnn_pkg::PROD_W'(samples[i]);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            products <= '0;
        end else begin
            products <= prod_next;          // Free running, follows the buffers
        end
    end

endmodule

`default_nettype wire

/* verilog/sum_relu_stage.sv */
// Adjacent product pair addition with ReLU, registered
`default_nettype none

module sum_relu_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  cnn_pkg::product_vec_t products,
    output cnn_pkg::sum_vec_t     sums
);

    cnn_pkg::sum_vec_t sum_next;

    for (genvar k = 0; k < cnn_pkg::NUM_SUMS; k++) begin : g_pair
        logic signed [cnn_pkg::SUM_W-1:0] pair_sum;

        // Full signed width so that -128 * -128 twice cannot overflow
        assign pair_sum = cnn_pkg::SUM_W'(products[2*k]) + cnn_pkg::SUM_W'(products[2*k+1]);

        // ReLU
        assign sum_next[k] = pair_sum[cnn_pkg::SUM_W-1] ? '0 : pair_sum;

        // Registered sums reach the pooling stage without a sign
        a_non_negative: assert property (@(posedge clk) disable iff (reset)
            !sums[k][cnn_pkg::SUM_W-1])
            else $error("negative partial sum at index %0d", k);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sums <= '0;
        end else begin
            sums <= sum_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/pool_serializer.sv */
// Average pooling, requantization, saturation and serial result output
`default_nettype none

module pool_serializer (
    input  logic                       clk,
    input  logic                       reset,
    input  cnn_pkg::sum_vec_t          sums,
    input  logic                       done,
    output logic [cnn_pkg::DATA_W-1:0] serial_result,
    output logic                       serial_result_valid
);

    logic [cnn_pkg::DATA_W-1:0]    pooled   [cnn_pkg::NUM_OUT];
    logic [cnn_pkg::DATA_W-1:0]    result_q [cnn_pkg::NUM_OUT];
    logic [cnn_pkg::OUT_IDX_W-1:0] out_idx;    // Next captured byte to send
    logic                          busy;       // Stream in progress

    for (genvar j = 0; j < cnn_pkg::NUM_OUT; j++) begin : g_pool
        logic [cnn_pkg::SUM_W:0] pair_total;
        logic [cnn_pkg::SUM_W:0] halved;
        logic [cnn_pkg::SUM_W:0] scaled;

        assign pair_total = (cnn_pkg::SUM_W+1)'(sums[2*j]) + (cnn_pkg::SUM_W+1)'(sums[2*j+1]);
        assign halved     = pair_total >> 1;                   // Average, truncating
        assign scaled     = halved >> cnn_pkg::RESULT_SHIFT;

        // Saturate anything above one unsigned byte
        assign pooled[j] = (|scaled[cnn_pkg::SUM_W:cnn_pkg::DATA_W]) ? '1
                                                                     : scaled[cnn_pkg::DATA_W-1:0];
    end

    // Stream control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy                <= 1'b0;
            out_idx             <= '0;
            serial_result_valid <= 1'b0;
        end else if (done) begin
            busy                <= 1'b1;
            out_idx             <= cnn_pkg::OUT_IDX_W'(1);     // Byte 0 leaves right away
            serial_result_valid <= 1'b1;
        end else if (busy) begin
            out_idx             <= out_idx + 1'b1;
            serial_result_valid <= 1'b1;
            if (out_idx == cnn_pkg::OUT_IDX_W'(cnn_pkg::NUM_OUT - 1))
                busy <= 1'b0;
        end else begin
            serial_result_valid <= 1'b0;
        end
    end

    // Result capture and output byte
    always_ff @(posedge clk) begin
        if (done) begin
            result_q      <= pooled;       // Sums may change once the next frame loads
            serial_result <= pooled[0];
        end else if (busy) begin
            serial_result <= result_q[out_idx];
        end
    end

    // The sequencer cannot finish a new frame before the last stream ends
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        done |-> !busy)
        else $error("done arrived while results were still streaming");

endmodule

`default_nettype wire

/* verilog/cnn_control.sv */
// Load and compute sequencer with write address counter and done pulse
`default_nettype none

module cnn_control (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  logic [7:0]                 serial_weight_data,
    input  logic                       serial_weight_valid,
    input  logic [7:0]                 serial_line_data,
    input  logic                       serial_line_valid,
    output logic                       weight_we,
    output logic                       line_we,
    output logic [cnn_pkg::ADDR_W-1:0] wr_addr,
    output logic [7:0]                 wr_data,
    output logic                       done
);

    cnn_pkg::ctrl_state_t              state;
    logic [cnn_pkg::ADDR_W-1:0]        addr_cnt;    // Next buffer entry to write
    logic [cnn_pkg::WAIT_W-1:0]        wait_cnt;    // Cycles spent in COMPUTE
    logic                              beat;
    logic                              last_beat;

    // A beat only counts in the matching load state
    assign weight_we = (state == cnn_pkg::LOAD_WEIGHTS) && serial_weight_valid;
    assign line_we   = (state == cnn_pkg::LOAD_LINE) && serial_line_valid;

    assign beat      = weight_we || line_we;
    assign last_beat = beat && (&addr_cnt);         // Sixteenth entry

    // Buffers write on the same edge that accepts the beat
    assign wr_addr = addr_cnt;
    assign wr_data = (state == cnn_pkg::LOAD_LINE) ? serial_line_data : serial_weight_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= cnn_pkg::IDLE;
            addr_cnt <= '0;
            wait_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= (state == cnn_pkg::DONE);       // Lags DONE by one cycle

            if (beat) begin
                addr_cnt <= addr_cnt + 1'b1;        // Wraps to zero after the last entry
            end

            case (state)
                cnn_pkg::IDLE: begin
                    if (start) begin
                        state    <= cnn_pkg::LOAD_WEIGHTS;
                        addr_cnt <= '0;
                    end
                end
                cnn_pkg::LOAD_WEIGHTS: begin
                    if (last_beat)
                        state <= cnn_pkg::LOAD_LINE;
                end
                cnn_pkg::LOAD_LINE: begin
                    if (last_beat) begin
                        state    <= cnn_pkg::COMPUTE;
                        wait_cnt <= '0;
                    end
                end
                cnn_pkg::COMPUTE: begin
                    // Wait for the multiplier and pair-sum registers to fill
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == cnn_pkg::WAIT_W'(cnn_pkg::PIPE_DEPTH - 1))
                        state <= cnn_pkg::DONE;
                end
                cnn_pkg::DONE: begin
                    state <= cnn_pkg::IDLE;
                end
                default: begin
                    state <= cnn_pkg::IDLE;
                end
            endcase
        end
    end

    // Only one buffer may be written per cycle
    a_single_we: assert property (@(posedge clk) disable iff (reset)
        !(weight_we && line_we))
        else $error("weight and line buffers written together");

    // Done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

`default_nettype wire

/* verilog/cnn_accel_top.sv */
// Line convolution engine top level: sequencer, operand buffers and datapath
`default_nettype none

module cnn_accel_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [7:0] serial_weight_data,
    input  logic       serial_weight_valid,
    input  logic [7:0] serial_line_data,
    input  logic       serial_line_valid,
    output logic [7:0] serial_result,
    output logic       serial_result_valid,
    output logic       done
);

    // Buffer write port shared by both buffers
    logic                            weight_we;
    logic                            line_we;
    logic [cnn_pkg::ADDR_W-1:0]      wr_addr;
    logic [cnn_pkg::DATA_W-1:0]      wr_data;

    // Datapath
    cnn_pkg::operand_vec_t           weights;
    cnn_pkg::operand_vec_t           samples;
    cnn_pkg::product_vec_t           products;
    cnn_pkg::sum_vec_t               sums;

    cnn_control u_control (
        .clk                 (clk),
        .reset               (reset),
        .start               (start),
        .serial_weight_data  (serial_weight_data),
        .serial_weight_valid (serial_weight_valid),
        .serial_line_data    (serial_line_data),
        .serial_line_valid   (serial_line_valid),
        .weight_we           (weight_we),
        .line_we             (line_we),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .done                (done)
    );

    operand_buffer u_weight_buf (
        .clk      (clk),
        .reset    (reset),
        .we       (weight_we),
        .addr     (wr_addr),
        .data     (wr_data),
        .contents (weights)
    );

    operand_buffer u_line_buf (
        .clk      (clk),
        .reset    (reset),
        .we       (line_we),
        .addr     (wr_addr),
        .data     (wr_data),
        .contents (samples)
    );

    mac_array u_mac (
        .clk      (clk),
        .reset    (reset),
        .weights  (weights),
        .samples  (samples),
        .products (products)
    );

    sum_relu_stage u_sum_relu (
        .clk      (clk),
        .reset    (reset),
        .products (products),
        .sums     (sums)
    );

    pool_serializer u_pool (
        .clk                 (clk),
        .reset               (reset),
        .sums                (sums),
        .done                (done),
        .serial_result       (serial_result),
        .serial_result_valid (serial_result_valid)
    );

endmodule

`default_nettype wire

/* tests/tb_cnn_model.svh */
// Reference model of one result byte, and the tasks that drive a frame into the DUT
`ifndef TB_CNN_MODEL_SVH
`define TB_CNN_MODEL_SVH

// Result byte j: ReLU of two pair sums, averaged, shifted down and clamped to a byte
function automatic logic [7:0] model_byte(input cnn_pkg::operand_vec_t w,
                                          input cnn_pkg::operand_vec_t s, input int j);
    int pair [2];
    int base;
    int pooled;
    base = j * (cnn_pkg::NUM_TAPS / cnn_pkg::NUM_OUT);
    for (int p = 0; p < 2; p++) begin
        pair[p] = int'($signed(w[base+2*p])) * int'($signed(s[base+2*p]))
                + int'($signed(w[base+2*p+1])) * int'($signed(s[base+2*p+1]));
        if (pair[p] < 0)
            pair[p] = 0;
    end
    pooled = ((pair[0] + pair[1]) / 2) >> cnn_pkg::RESULT_SHIFT;
    return (pooled > 255) ? 8'hff : 8'(pooled);
endfunction

task automatic pulse_start();
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
endtask

// Two idle cycles, with a start pulse the DUT must ignore while loading
task automatic stall_with_start();
    serial_weight_valid <= 1'b0;
    serial_line_valid   <= 1'b0;
    serial_weight_data  <= 8'h5a;
    start               <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
endtask

task automatic load_stream(input cnn_pkg::operand_vec_t v, input bit is_line, input bit gaps);
    for (int i = 0; i < cnn_pkg::NUM_TAPS; i++) begin
        if (gaps && (i % 5 == 3))
            stall_with_start();
        if (is_line) begin
            serial_line_data  <= v[i];
            serial_line_valid <= 1'b1;
            last_line_beat    <= (i == cnn_pkg::NUM_TAPS - 1);  // Marks edge 0
        end else begin
            serial_weight_data  <= v[i];
            serial_weight_valid <= 1'b1;
        end
        @(posedge clk);
    end
    serial_weight_valid <= 1'b0;
    serial_line_valid   <= 1'b0;
    last_line_beat      <= 1'b0;
endtask

// Queue the expected bytes, load one frame and wait for its done pulse
task automatic run_frame(input cnn_pkg::operand_vec_t w, input cnn_pkg::operand_vec_t s,
                         input bit gaps, input int tag);
    for (int j = 0; j < cnn_pkg::NUM_OUT; j++) begin
        exp_bytes[exp_count] = model_byte(w, s, j);
        exp_test[exp_count]  = test_name;
        exp_tag[exp_count]   = tag;
        exp_count            = exp_count + 1'b1;
    end
    pulse_start();
    load_stream(w, 1'b0, gaps);
    load_stream(s, 1'b1, gaps);
    do begin
        @(posedge clk);
    end while (!done);
endtask

`endif

/* tests/tb_cnn_accel.sv */
// Testbench top: clock, reset, frame tests, checking assertions, watchdog and report
`default_nettype none

module tb_cnn_accel;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_FRAMES   = 24;                    // Tests 2 to 5 one each, test 6 twenty
    localparam int MAX_BYTES    = NUM_FRAMES * cnn_pkg::NUM_OUT;
    localparam int IDX_W        = $clog2(MAX_BYTES + 1);
    localparam int WATCHDOG_CYC = NUM_FRAMES * 60 + 200;
    localparam int TAG_PLAIN    = 0;
    localparam int TAG_RELU     = 1;
    localparam int TAG_SAT      = 2;

    logic       clk;
    logic       reset;
    logic       start;
    logic [7:0] serial_weight_data;
    logic       serial_weight_valid;
    logic [7:0] serial_line_data;
    logic       serial_line_valid;
    logic [7:0] serial_result;
    logic       serial_result_valid;
    logic       done;

    logic             last_line_beat = 1'b0;         // High with the final line beat
    logic [IDX_W-1:0] exp_count = '0;
    logic [IDX_W-1:0] rx_count = '0;                 // Result bytes seen so far
    logic [7:0]       exp_bytes [MAX_BYTES];
    string            exp_test  [MAX_BYTES];
    int               exp_tag   [MAX_BYTES];
    string            test_name = "reset";
    int               err_count = 0;
    int               errs_base;
    int               num_tests = 0;
    int               fail_tests = 0;

    cnn_accel_top u_dut (
        .clk                 (clk),
        .reset               (reset),
        .start               (start),
        .serial_weight_data  (serial_weight_data),
        .serial_weight_valid (serial_weight_valid),
        .serial_line_data    (serial_line_data),
        .serial_line_valid   (serial_line_valid),
        .serial_result       (serial_result),
        .serial_result_valid (serial_result_valid),
        .done                (done)
    );

    `include "tb_cnn_model.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (serial_result_valid)
            rx_count <= rx_count + 1'b1;
    end

    // done follows the last line beat by four samples, and only then
    a_done_timing: assert property (@(posedge clk) disable iff (reset)
        done == $past(last_line_beat, 4))
        else begin
            err_count++;
            $display("done pulse out of place relative to the last line beat in %s", test_name);
        end

    // Exactly four valid bytes, on the samples five to eight after the last line beat
    a_valid_window: assert property (@(posedge clk) disable iff (reset)
        serial_result_valid == ($past(last_line_beat, 5) || $past(last_line_beat, 6) ||
                                $past(last_line_beat, 7) || $past(last_line_beat, 8)))
        else begin
            err_count++;
            $display("serial_result_valid out of its four-cycle window in %s", test_name);
        end

    a_result_value: assert property (@(posedge clk) disable iff (reset)
        serial_result_valid |-> serial_result == exp_bytes[rx_count])
        else begin
            err_count++;
            $display("Error %s: expected %02h actual %02h", exp_test[$sampled(rx_count)],
                     exp_bytes[$sampled(rx_count)], $sampled(serial_result));
        end

    a_relu_zero: assert property (@(posedge clk) disable iff (reset)
        (serial_result_valid && exp_tag[rx_count] == TAG_RELU) |-> serial_result == 8'h00)
        else begin
            err_count++;
            $display("Error %s: expected 00 actual %02h", exp_test[$sampled(rx_count)],
                     $sampled(serial_result));
        end

    a_saturation: assert property (@(posedge clk) disable iff (reset)
        (serial_result_valid && exp_tag[rx_count] == TAG_SAT) |-> serial_result == 8'hff)
        else begin
            err_count++;
            $display("Error %s: expected ff actual %02h", exp_test[$sampled(rx_count)],
                     $sampled(serial_result));
        end

    task automatic begin_test(input string name);
        test_name = name;
        errs_base = err_count;
        num_tests++;
    endtask

    task automatic finish_test();
        int errs;
        while (rx_count != exp_count)
            @(posedge clk);
        repeat (2) @(posedge clk);                      // Edge after the last byte is checked too
        errs = err_count - errs_base;
        if (errs == 0) begin
            $display("%s: ok", test_name);
        end else begin
            fail_tests++;
            $display("%s: failed with %0d errors", test_name, errs);
        end
    endtask

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Timeout in %s: the DUT stopped producing results", test_name);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        cnn_pkg::operand_vec_t w_vec;
        cnn_pkg::operand_vec_t s_vec;
        cnn_pkg::operand_vec_t w_fix;
        cnn_pkg::operand_vec_t s_fix;
        void'($urandom(32'h8456_741e));
        reset               = 1'b1;
        start               = 1'b0;
        serial_weight_data  = 8'h00;
        serial_weight_valid = 1'b0;
        serial_line_data    = 8'h00;
        serial_line_valid   = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Stray beats in IDLE must not start anything
        begin_test("reset_quiet");
        for (int i = 0; i < 12; i++) begin
            serial_weight_data  <= 8'($urandom);
            serial_line_data    <= 8'($urandom);
            serial_weight_valid <= i[0];
            serial_line_valid   <= ~i[0];
            @(posedge clk);
        end
        serial_weight_valid <= 1'b0;
        serial_line_valid   <= 1'b0;
        finish_test();

        begin_test("fixed_frame");
        for (int i = 0; i < cnn_pkg::NUM_TAPS; i++) begin
            w_fix[i] = 8'(8 * i - 40);
            s_fix[i] = 8'(6 * i + 10);
        end
        run_frame(w_fix, s_fix, 1'b0, TAG_PLAIN);
        finish_test();

        begin_test("relu_zero");
        for (int i = 0; i < cnn_pkg::NUM_TAPS; i++) begin
            w_vec[i] = 8'h7f;
            s_vec[i] = 8'(-100 - i);                    // Every product negative
        end
        run_frame(w_vec, s_vec, 1'b0, TAG_RELU);
        finish_test();

        begin_test("saturation");
        for (int i = 0; i < cnn_pkg::NUM_TAPS; i++) begin
            w_vec[i] = i[0] ? 8'h80 : 8'h7f;
            s_vec[i] = i[0] ? 8'h80 : 8'(112 + i);      // -128 * -128 on odd taps
        end
        run_frame(w_vec, s_vec, 1'b0, TAG_SAT);
        finish_test();

        begin_test("stalled_load");
        run_frame(w_fix, s_fix, 1'b1, TAG_PLAIN);
        finish_test();

        // Each start lands while the previous frame is still streaming
        begin_test("random_overlap");
        repeat (20) begin
            for (int i = 0; i < cnn_pkg::NUM_TAPS; i++) begin
                w_vec[i] = 8'($urandom);
                s_vec[i] = 8'($urandom);
            end
            run_frame(w_vec, s_vec, 1'b0, TAG_PLAIN);
        end
        finish_test();

        $display("%0d tests run, %0d failed, %0d check errors", num_tests, fail_tests, err_count);
        if (err_count == 0 && fail_tests == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+tests
verilog/cnn_pkg.sv
verilog/operand_buffer.sv
verilog/mac_array.sv
verilog/sum_relu_stage.sv
verilog/pool_serializer.sv
verilog/cnn_control.sv
verilog/cnn_accel_top.sv
tests/tb_cnn_accel.sv

/* run.sh */
#!/bin/sh
# Build the line convolution testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f list.f --top-module tb_cnn_accel -o sim_cnn_accel

result=$(./obj_dir/sim_cnn_accel)
echo "$result"

# Exit status follows the pass line
echo "$result" | grep -qx "TEST PASS"
